//--- source/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    typedef logic [31:0] vaddr_t;

    localparam logic [5:0] OP_JIRL = 6'b010011;
    localparam logic [5:0] OP_B    = 6'b010100;
    localparam logic [5:0] OP_BL   = 6'b010101;
    localparam logic [5:0] OP_BEQ  = 6'b010110;
    localparam logic [5:0] OP_BNE  = 6'b010111;
    localparam logic [5:0] OP_BLT  = 6'b011000;
    localparam logic [5:0] OP_BGE  = 6'b011001;
    localparam logic [5:0] OP_BLTU = 6'b011010;
    localparam logic [5:0] OP_BGEU = 6'b011011;

    localparam logic [4:0] REG_RA = 5'd1;   // link register

    // 26-bit offset of b and bl, the low half sits above the high half
    typedef struct packed {
        logic [5:0]  op;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi;
    } inst_off_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [15:0] imm16;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_reg_t;

    typedef union packed {
        inst_off_t off;
        inst_reg_t rg;
    } inst_t;

endpackage

`default_nettype wire

//--- source/ras.sv
`default_nettype none

module ras #(
    parameter int DEPTH = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              push_i,
    input  logic              pop_i,
    input  fetch_pkg::vaddr_t push_addr_i,
    output fetch_pkg::vaddr_t top_o,
    output logic              top_valid_o
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    fetch_pkg::vaddr_t stack_q [DEPTH];
    logic [PW-1:0]     top_q;       // index of the top entry
    logic [PW:0]       count_q;
    logic [PW-1:0]     top_inc;
    logic [PW-1:0]     top_dec;
    logic              do_pop;

    assign top_inc = (top_q == PW'(DEPTH - 1)) ? '0 : top_q + 1'b1;
    assign top_dec = (top_q == '0) ? PW'(DEPTH - 1) : top_q - 1'b1;
    assign do_pop  = pop_i & (count_q != '0);   // pop on empty is ignored

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            top_q   <= '0;
            count_q <= '0;
        end else if (push_i && !do_pop) begin
            top_q <= top_inc;
            if (count_q != (PW + 1)'(DEPTH))
                count_q <= count_q + 1'b1;  // oldest entry gets overwritten
        end else if (do_pop && !push_i) begin
            top_q   <= top_dec;
            count_q <= count_q - 1'b1;
        end
    end

    // push with pop just replaces the top
    always_ff @(posedge clk) begin
        if (push_i && do_pop)
            stack_q[top_q] <= push_addr_i;
        else if (push_i)
            stack_q[top_inc] <= push_addr_i;
    end

    assign top_o       = stack_q[top_q];
    assign top_valid_o = (count_q != '0);

endmodule

`default_nettype wire

//--- source/btb.sv
`default_nettype none

module btb #(
    parameter int BTB_ENTRIES = 16
) (
    input  logic              clk,
    input  logic              rst_n,
    input  fetch_pkg::vaddr_t lk_pc_i,
    output logic              lk_hit_o,
    output fetch_pkg::vaddr_t lk_target_o,
    input  logic              fill_valid_i,
    input  fetch_pkg::vaddr_t fill_pc_i,
    input  fetch_pkg::vaddr_t fill_target_i,
    input  logic              inv_valid_i,
    input  fetch_pkg::vaddr_t inv_pc_i
);

    localparam int IW = $clog2(BTB_ENTRIES);
    localparam int TW = 30 - IW;

    logic [BTB_ENTRIES-1:0] valid_q;
    logic [TW-1:0]          tag_q    [BTB_ENTRIES];
    fetch_pkg::vaddr_t      target_q [BTB_ENTRIES];

    logic [IW-1:0] lk_idx;
    logic [IW-1:0] fill_idx;
    logic [IW-1:0] inv_idx;

    // word aligned, so index starts at bit 2
    assign lk_idx   = lk_pc_i[IW+1:2];
    assign fill_idx = fill_pc_i[IW+1:2];
    assign inv_idx  = inv_pc_i[IW+1:2];

    assign lk_hit_o    = valid_q[lk_idx] && (tag_q[lk_idx] == lk_pc_i[31:IW+2]);
    assign lk_target_o = target_q[lk_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            if (fill_valid_i)
                valid_q[fill_idx] <= 1'b1;
            if (inv_valid_i)
                valid_q[inv_idx] <= 1'b0;   // last write, so invalidate wins
        end
    end

    always_ff @(posedge clk) begin
        if (fill_valid_i) begin
            tag_q[fill_idx]    <= fill_pc_i[31:IW+2];
            target_q[fill_idx] <= fill_target_i;
        end
    end

endmodule

`default_nettype wire

//--- source/fetch1.sv
`default_nettype none

module fetch1 #(
    parameter fetch_pkg::vaddr_t RESET_PC = 32'h1c00_0000
) (
    input  logic              clk,
    input  logic              rst_n,
    output logic              wb_cyc_o,
    output logic              wb_stb_o,
    output fetch_pkg::vaddr_t wb_adr_o,
    input  logic [31:0]       wb_dat_i,
    input  logic              wb_ack_i,
    input  logic              f2_ready_i,
    input  logic              redir_valid_i,
    input  fetch_pkg::vaddr_t redir_pc_i,
    input  logic              flush_i,
    input  fetch_pkg::vaddr_t flush_pc_i,
    output fetch_pkg::vaddr_t lk_pc_o,
    input  logic              lk_hit_i,
    input  fetch_pkg::vaddr_t lk_target_i,
    output logic              f1_valid_o,
    output fetch_pkg::vaddr_t f1_pc_o,
    output fetch_pkg::vaddr_t f1_npc_o,
    output logic              f1_pred_o,
    output logic [31:0]       f1_inst_o
);

    fetch_pkg::vaddr_t pc_q;        // next address to fetch
    fetch_pkg::vaddr_t adr_q;       // address of the read in flight
    logic              busy_q;
    logic              kill_q;      // read in flight is stale
    logic              buf_valid_q;
    fetch_pkg::vaddr_t buf_pc_q;
    fetch_pkg::vaddr_t buf_npc_q;
    logic              buf_pred_q;
    logic [31:0]       buf_inst_q;

    logic              redirect;
    fetch_pkg::vaddr_t redirect_pc;
    fetch_pkg::vaddr_t start_pc;
    fetch_pkg::vaddr_t pred_npc;
    logic              ack;
    logic              start;
    logic              capture;

    // flush from the backend beats the fetch2 redirect
    assign redirect    = flush_i | redir_valid_i;
    assign redirect_pc = flush_i ? flush_pc_i : redir_pc_i;
    assign start_pc    = redirect ? redirect_pc : pc_q;

    assign ack     = busy_q & wb_ack_i;
    assign start   = ~busy_q & (~buf_valid_q | f2_ready_i | redirect); // buffer free at next ack
    assign capture = ack & ~kill_q & ~redirect;

    assign lk_pc_o  = adr_q;
    assign pred_npc = lk_hit_i ? lk_target_i : adr_q + 32'd4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q        <= RESET_PC;
            busy_q      <= 1'b0;
            kill_q      <= 1'b0;
            buf_valid_q <= 1'b0;
        end else begin
            if (redirect)
                pc_q <= redirect_pc;
            else if (capture)
                pc_q <= pred_npc;

            if (start)
                busy_q <= 1'b1;
            else if (ack)
                busy_q <= 1'b0;

            if (ack)
                kill_q <= 1'b0;
            else if (redirect && busy_q)
                kill_q <= 1'b1;   // keep stb until ack, then drop the word

            if (redirect)
                buf_valid_q <= 1'b0;
            else if (capture)
                buf_valid_q <= 1'b1;
            else if (f2_ready_i)
                buf_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            adr_q <= start_pc;
        if (capture) begin
            buf_pc_q   <= adr_q;
            buf_npc_q  <= pred_npc;
            buf_pred_q <= lk_hit_i;
            buf_inst_q <= wb_dat_i;
        end
    end

    assign wb_cyc_o = busy_q;
    assign wb_stb_o = busy_q;
    assign wb_adr_o = adr_q;

    assign f1_valid_o = buf_valid_q;
    assign f1_pc_o    = buf_pc_q;
    assign f1_npc_o   = buf_npc_q;
    assign f1_pred_o  = buf_pred_q;
    assign f1_inst_o  = buf_inst_q;

endmodule

`default_nettype wire

//--- source/fetch2.sv
`default_nettype none

module fetch2 #(
    parameter int RAS_DEPTH = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              f1_valid_i,
    input  fetch_pkg::vaddr_t f1_pc_i,
    input  fetch_pkg::vaddr_t f1_npc_i,
    input  logic              f1_pred_i,
    input  logic [31:0]       f1_inst_i,
    output logic              f2_ready_o,
    input  logic              decode_stall_i,
    input  logic              flush_i,
    output logic              redir_valid_o,
    output fetch_pkg::vaddr_t redir_pc_o,
    output logic              btb_fill_valid_o,
    output fetch_pkg::vaddr_t btb_fill_pc_o,
    output fetch_pkg::vaddr_t btb_fill_target_o,
    output logic              btb_inv_valid_o,
    output fetch_pkg::vaddr_t btb_inv_pc_o,
    output logic              inst_valid_o,
    output logic [31:0]       inst_o,
    output fetch_pkg::vaddr_t inst_pc_o,
    output fetch_pkg::vaddr_t inst_npc_o
);

    logic              r_valid;
    fetch_pkg::vaddr_t r_pc;
    fetch_pkg::vaddr_t r_npc;
    logic              r_pred;
    fetch_pkg::inst_t  r_inst;

    logic              stall;
    logic              fire;       // item handed to decode this cycle
    fetch_pkg::vaddr_t pc4;
    fetch_pkg::vaddr_t jump_to;
    fetch_pkg::vaddr_t corr_npc;
    fetch_pkg::vaddr_t ras_top;
    logic              ras_valid;

    logic inst_jirl;
    logic inst_b;
    logic inst_bl;
    logic inst_cond;
    logic is_br;
    logic is_return;
    logic bad_pred;
    logic ret_hit;

    assign stall      = decode_stall_i & r_valid;
    assign f2_ready_o = ~stall;
    assign fire       = r_valid & ~decode_stall_i & ~flush_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            r_valid <= 1'b0;
        else if (flush_i || redir_valid_o)
            r_valid <= 1'b0;   // item behind a redirect is off path
        else if (!stall)
            r_valid <= f1_valid_i;
    end

    always_ff @(posedge clk) begin
        if (!stall && f1_valid_i) begin
            r_pc   <= f1_pc_i;
            r_npc  <= f1_npc_i;
            r_pred <= f1_pred_i;
            r_inst <= f1_inst_i;
        end
    end

    always_comb begin
        inst_jirl = 1'b0;
        inst_b    = 1'b0;
        inst_bl   = 1'b0;
        inst_cond = 1'b0;
        case (r_inst.off.op)
            fetch_pkg::OP_JIRL: inst_jirl = 1'b1;
            fetch_pkg::OP_B:    inst_b    = 1'b1;
            fetch_pkg::OP_BL:   inst_bl   = 1'b1;
            fetch_pkg::OP_BEQ, fetch_pkg::OP_BNE, fetch_pkg::OP_BLT,
            fetch_pkg::OP_BGE, fetch_pkg::OP_BLTU, fetch_pkg::OP_BGEU:
                inst_cond = 1'b1;
            default: ;
        endcase
    end

    assign is_br     = inst_jirl | inst_b | inst_bl | inst_cond;
    assign is_return = inst_jirl && (r_inst.rg.rd == 5'd0)
                       && (r_inst.rg.rj == fetch_pkg::REG_RA) && (r_inst.rg.imm16 == 16'd0);

    assign pc4     = r_pc + 32'd4;
    assign jump_to = r_pc + {{4{r_inst.off.offs_hi[9]}}, r_inst.off.offs_hi,
                             r_inst.off.offs_lo, 2'b00};

    assign bad_pred = ~is_br & r_pred & (r_npc != pc4);
    assign ret_hit  = is_return & ras_valid;

    always_comb begin
        if (bad_pred)
            corr_npc = pc4;
        else if (inst_b || inst_bl)
            corr_npc = jump_to;
        else if (ret_hit)
            corr_npc = ras_top;
        else
            corr_npc = r_npc;   // conditional branches left to the backend
    end

    ras #(
        .DEPTH(RAS_DEPTH)
    ) u_ras (
        .clk        (clk),
        .rst_n      (rst_n),
        .push_i     (fire & inst_bl),
        .pop_i      (fire & ret_hit),
        .push_addr_i(pc4),
        .top_o      (ras_top),
        .top_valid_o(ras_valid)
    );

    assign redir_valid_o = fire & (corr_npc != r_npc);
    assign redir_pc_o    = corr_npc;

    assign btb_fill_valid_o  = fire & (inst_b | inst_bl);
    assign btb_fill_pc_o     = r_pc;
    assign btb_fill_target_o = jump_to;
    assign btb_inv_valid_o   = fire & bad_pred;
    assign btb_inv_pc_o      = r_pc;

    assign inst_valid_o = r_valid & ~flush_i;
    assign inst_o       = r_inst;
    assign inst_pc_o    = r_pc;
    assign inst_npc_o   = corr_npc;

endmodule

`default_nettype wire

//--- source/fetch_top.sv
`default_nettype none

module fetch_top #(
    parameter fetch_pkg::vaddr_t RESET_PC    = 32'h1c00_0000,
    parameter int                BTB_ENTRIES = 16,
    parameter int                RAS_DEPTH   = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    output logic              wb_cyc_o,
    output logic              wb_stb_o,
    output fetch_pkg::vaddr_t wb_adr_o,
    input  logic [31:0]       wb_dat_i,
    input  logic              wb_ack_i,
    input  logic              decode_stall_i,
    input  logic              flush_i,
    input  fetch_pkg::vaddr_t flush_pc_i,
    output logic              inst_valid_o,
    output logic [31:0]       inst_o,
    output fetch_pkg::vaddr_t inst_pc_o,
    output fetch_pkg::vaddr_t inst_npc_o
);

    fetch_pkg::vaddr_t lk_pc;
    fetch_pkg::vaddr_t lk_target;
    logic              lk_hit;
    logic              f1_valid;
    fetch_pkg::vaddr_t f1_pc;
    fetch_pkg::vaddr_t f1_npc;
    logic              f1_pred;
    logic [31:0]       f1_inst;
    logic              f2_ready;
    logic              redir_valid;
    fetch_pkg::vaddr_t redir_pc;
    logic              btb_fill_valid;
    fetch_pkg::vaddr_t btb_fill_pc;
    fetch_pkg::vaddr_t btb_fill_target;
    logic              btb_inv_valid;
    fetch_pkg::vaddr_t btb_inv_pc;

    fetch1 #(
        .RESET_PC(RESET_PC)
    ) u_fetch1 (
        .clk(clk), .rst_n(rst_n),
        .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_adr_o(wb_adr_o),
        .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i),
        .f2_ready_i(f2_ready),
        .redir_valid_i(redir_valid), .redir_pc_i(redir_pc),
        .flush_i(flush_i), .flush_pc_i(flush_pc_i),
        .lk_pc_o(lk_pc), .lk_hit_i(lk_hit), .lk_target_i(lk_target),
        .f1_valid_o(f1_valid), .f1_pc_o(f1_pc), .f1_npc_o(f1_npc),
        .f1_pred_o(f1_pred), .f1_inst_o(f1_inst)
    );

    fetch2 #(
        .RAS_DEPTH(RAS_DEPTH)
    ) u_fetch2 (
        .clk(clk), .rst_n(rst_n),
        .f1_valid_i(f1_valid), .f1_pc_i(f1_pc), .f1_npc_i(f1_npc),
        .f1_pred_i(f1_pred), .f1_inst_i(f1_inst),
        .f2_ready_o(f2_ready),
        .decode_stall_i(decode_stall_i), .flush_i(flush_i),
        .redir_valid_o(redir_valid), .redir_pc_o(redir_pc),
        .btb_fill_valid_o(btb_fill_valid), .btb_fill_pc_o(btb_fill_pc),
        .btb_fill_target_o(btb_fill_target),
        .btb_inv_valid_o(btb_inv_valid), .btb_inv_pc_o(btb_inv_pc),
        .inst_valid_o(inst_valid_o), .inst_o(inst_o),
        .inst_pc_o(inst_pc_o), .inst_npc_o(inst_npc_o)
    );

    btb #(
        .BTB_ENTRIES(BTB_ENTRIES)
    ) u_btb (
        .clk(clk), .rst_n(rst_n),
        .lk_pc_i(lk_pc), .lk_hit_o(lk_hit), .lk_target_o(lk_target),
        .fill_valid_i(btb_fill_valid), .fill_pc_i(btb_fill_pc),
        .fill_target_i(btb_fill_target),
        .inv_valid_i(btb_inv_valid), .inv_pc_i(btb_inv_pc)
    );

endmodule

`default_nettype wire

//--- testbench/imem_model.sv
`default_nettype none

module imem_model #(
    parameter int WORDS = 256
) (
    input  logic        clk,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic [31:0] wb_adr_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o
);

    localparam int AW = $clog2(WORDS);

    logic [31:0] mem [WORDS];   // loaded and patched by the testbench
    logic        pending;
    int unsigned wait_cnt;

    initial begin
        wb_ack_o = 1'b0;
        wb_dat_o = '0;
        pending  = 1'b0;
        wait_cnt = 0;
    end

    // responds on the falling edge, the master samples on the rising one
    always @(negedge clk) begin
        if (wb_ack_o) begin
            wb_ack_o = 1'b0;    // single cycle ack
            pending  = 1'b0;
        end else if (wb_cyc_i && wb_stb_i) begin
            if (!pending) begin
                pending  = 1'b1;
                wait_cnt = $urandom % 4;    // 0 to 3 wait states
            end
            if (wait_cnt == 0) begin
                wb_ack_o = 1'b1;
                wb_dat_o = mem[wb_adr_i[AW+1:2]];
            end else begin
                wait_cnt = wait_cnt - 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/fetch_chk.sv
`default_nettype none

module fetch_chk (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wb_cyc_o,
    input  logic              wb_stb_o,
    input  fetch_pkg::vaddr_t wb_adr_o,
    input  logic              wb_ack_i,
    input  logic              flush_i,
    input  logic              inst_valid_o
);

    int fail_count;

    initial fail_count = 0;

    stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb_o |-> wb_cyc_o)
        else begin
            $error("wb_stb_o high while wb_cyc_o is low");
            fail_count++;
        end

    // request held with a steady address until ack
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o))
        else begin
            $error("bus request dropped or address changed before ack");
            fail_count++;
        end

    one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb_o && wb_ack_i |=> !wb_stb_o)
        else begin
            $error("new wb_stb_o right after ack, back to back reads");
            fail_count++;
        end

    flush_kills: assert property (@(posedge clk) disable iff (!rst_n)
        flush_i |=> !inst_valid_o)
        else begin
            $error("inst_valid_o high in the cycle after flush_i");
            fail_count++;
        end

endmodule

bind fetch_top fetch_chk u_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_cyc_o    (wb_cyc_o),
    .wb_stb_o    (wb_stb_o),
    .wb_adr_o    (wb_adr_o),
    .wb_ack_i    (wb_ack_i),
    .flush_i     (flush_i),
    .inst_valid_o(inst_valid_o)
);

`default_nettype wire

//--- testbench/tb_fetch.sv
`default_nettype none

module tb_fetch;

    localparam fetch_pkg::vaddr_t RESET_PC  = 32'h1c00_0000;
    localparam int                MEM_WORDS = 256;
    localparam int                ITEM_WAIT = 20;   // cycles allowed per item

    logic              clk;
    logic              rst_n;
    logic              wb_cyc;
    logic              wb_stb;
    fetch_pkg::vaddr_t wb_adr;
    logic [31:0]       wb_dat;
    logic              wb_ack;
    logic              decode_stall;
    logic              flush;
    fetch_pkg::vaddr_t flush_pc;
    logic              inst_valid;
    logic [31:0]       inst;
    fetch_pkg::vaddr_t inst_pc;
    fetch_pkg::vaddr_t inst_npc;

    int                errors;
    int                delivered;
    logic              stall_en;
    logic              timed_out;
    fetch_pkg::vaddr_t exp_pc;
    fetch_pkg::vaddr_t call_stack [$];  // return addresses of unmatched bl

    fetch_top #(
        .RESET_PC   (RESET_PC),
        .BTB_ENTRIES(16),
        .RAS_DEPTH  (8)
    ) uut (
        .clk(clk), .rst_n(rst_n),
        .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_adr_o(wb_adr),
        .wb_dat_i(wb_dat), .wb_ack_i(wb_ack),
        .decode_stall_i(decode_stall), .flush_i(flush), .flush_pc_i(flush_pc),
        .inst_valid_o(inst_valid), .inst_o(inst),
        .inst_pc_o(inst_pc), .inst_npc_o(inst_npc)
    );

    imem_model #(
        .WORDS(MEM_WORDS)
    ) u_mem (
        .clk(clk), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_adr_i(wb_adr),
        .wb_dat_o(wb_dat), .wb_ack_o(wb_ack)
    );

    function automatic fetch_pkg::vaddr_t pc_of(input int idx);
        return RESET_PC + idx * 4;
    endfunction

    function automatic logic [31:0] word_at(input fetch_pkg::vaddr_t pc);
        return u_mem.mem[(pc - RESET_PC) >> 2];
    endfunction

    // op 000011 makes a filler word that is no branch
    function automatic logic [31:0] make_plain(input int idx);
        return {6'b000011, 8'(idx), 8'(~idx), 10'(idx)};
    endfunction

    function automatic logic [31:0] make_jump(input logic [5:0] op, input int from,
                                              input int to);
        fetch_pkg::inst_t w;
        logic [25:0]      offs;
        offs          = 26'(to - from);
        w.off.op      = op;
        w.off.offs_hi = offs[25:16];
        w.off.offs_lo = offs[15:0];
        return w;
    endfunction

    function automatic logic [31:0] make_reg(input logic [5:0] op, input logic [15:0] imm,
                                             input logic [4:0] rj, input logic [4:0] rd);
        fetch_pkg::inst_t w;
        w.rg.op    = op;
        w.rg.imm16 = imm;
        w.rg.rj    = rj;
        w.rg.rd    = rd;
        return w;
    endfunction

    function automatic logic is_return_word(input logic [31:0] word);
        fetch_pkg::inst_t w;
        w = word;
        return w.rg.op == fetch_pkg::OP_JIRL && w.rg.rd == 5'd0
               && w.rg.rj == fetch_pkg::REG_RA && w.rg.imm16 == 16'd0;
    endfunction

    function automatic fetch_pkg::vaddr_t ref_next_pc(input fetch_pkg::vaddr_t pc,
                                                      input logic [31:0] word);
        fetch_pkg::inst_t   w;
        logic signed [25:0] offs;
        int                 delta;
        w     = word;
        offs  = {w.off.offs_hi, w.off.offs_lo};
        delta = offs;   // sign extended
        if (w.off.op == fetch_pkg::OP_B || w.off.op == fetch_pkg::OP_BL)
            return pc + delta * 4;
        if (is_return_word(word) && call_stack.size() > 0)
            return call_stack[$];
        return pc + 32'd4;  // conditional branches and plain jirl fall through
    endfunction

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        errors++;
        $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic check_item;
        logic [31:0]       word;
        fetch_pkg::vaddr_t npc;
        fetch_pkg::inst_t  w;
        word = word_at(exp_pc);
        npc  = ref_next_pc(exp_pc, word);
        w    = word;
        assert (inst_pc == exp_pc) else value_error("inst_pc_o", inst_pc, exp_pc);
        assert (inst == word) else value_error("inst_o", inst, word);
        assert (inst_npc == npc) else value_error("inst_npc_o", inst_npc, npc);
        if (w.off.op == fetch_pkg::OP_BL)
            call_stack.push_back(exp_pc + 32'd4);
        else if (is_return_word(word) && call_stack.size() > 0)
            void'(call_stack.pop_back());
        exp_pc = npc;
        delivered++;
    endtask

    // main loop 0..9 with three nested calls and spare loops at 10 and 20
    task automatic load_program;
        for (int i = 0; i < MEM_WORDS; i++)
            u_mem.mem[i] = make_plain(i);
        u_mem.mem[3]  = make_reg(fetch_pkg::OP_BEQ, 16'h0010, 5'd4, 5'd5);
        u_mem.mem[5]  = make_reg(fetch_pkg::OP_JIRL, 16'h0000, 5'd2, 5'd1);
        u_mem.mem[8]  = make_jump(fetch_pkg::OP_BL, 8, 40);
        u_mem.mem[9]  = make_jump(fetch_pkg::OP_B, 9, 0);
        u_mem.mem[16] = make_jump(fetch_pkg::OP_B, 16, 10);
        u_mem.mem[28] = make_jump(fetch_pkg::OP_B, 28, 20);
        u_mem.mem[42] = make_jump(fetch_pkg::OP_BL, 42, 48);
        u_mem.mem[43] = make_reg(fetch_pkg::OP_JIRL, 16'h0000, fetch_pkg::REG_RA, 5'd0);
        u_mem.mem[50] = make_jump(fetch_pkg::OP_BL, 50, 56);
        u_mem.mem[51] = make_reg(fetch_pkg::OP_JIRL, 16'h0000, fetch_pkg::REG_RA, 5'd0);
        u_mem.mem[57] = make_reg(fetch_pkg::OP_JIRL, 16'h0000, fetch_pkg::REG_RA, 5'd0);
    endtask

    task automatic note_timeout(input string why);
        timed_out = 1'b1;
        $display("%s", why);
    endtask

    task automatic wait_items(input int n);
        int target;
        int cycles;
        if (timed_out)
            return;
        target = delivered + n;
        cycles = 0;
        while (delivered < target && cycles < n * ITEM_WAIT + 100) begin
            @(negedge clk);
            cycles++;
        end
        if (delivered < target)
            note_timeout($sformatf("timeout: only %0d of %0d items delivered",
                                   delivered, target));
    endtask

    task automatic wait_bus_busy;
        int cycles;
        if (timed_out)
            return;
        cycles = 0;
        @(negedge clk);
        while (!wb_cyc && cycles < 50) begin
            @(negedge clk);
            cycles++;
        end
        if (!wb_cyc)
            note_timeout("timeout: no bus read started");
    endtask

    // called on a falling edge
    task automatic flush_to(input fetch_pkg::vaddr_t pc);
        flush_pc = pc;
        flush    = 1'b1;
        @(negedge clk);
        flush    = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin : stall_gen
        decode_stall = 1'b0;
        forever begin
            @(negedge clk);
            decode_stall = stall_en && ($urandom % 3 == 0);
        end
    end

    // outputs settle after the falling edge and hold until the rising one
    initial begin : compare
        logic              held;
        logic [31:0]       held_inst;
        fetch_pkg::vaddr_t held_pc;
        fetch_pkg::vaddr_t held_npc;
        held      = 1'b0;
        exp_pc    = RESET_PC;
        delivered = 0;
        forever begin
            @(negedge clk);
            #2;
            if (!rst_n) begin
                held = 1'b0;
            end else if (flush) begin
                held   = 1'b0;
                exp_pc = flush_pc;
            end else begin
                if (held) begin
                    assert (inst_valid && inst_pc == held_pc && inst == held_inst
                            && inst_npc == held_npc)
                    else begin
                        errors++;
                        $display("%0t: outputs to decode changed while decode_stall_i was high",
                                 $time);
                    end
                end
                if (inst_valid && !decode_stall)
                    check_item();
                held      = inst_valid && decode_stall;
                held_inst = inst;
                held_pc   = inst_pc;
                held_npc  = inst_npc;
            end
        end
    end

    initial begin : main
        void'($urandom(32'hcd1f_98cc));
        errors    = 0;
        timed_out = 1'b0;
        stall_en  = 1'b0;
        rst_n     = 1'b0;
        flush     = 1'b0;
        flush_pc  = '0;
        load_program();
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        wait_items(100);    // sequential start, loop by b, nested calls

        stall_en = 1'b1;
        wait_items(80);
        stall_en = 1'b0;

        wait_bus_busy();    // flush with a read in flight
        flush_to(pc_of(20));
        wait_items(30);

        u_mem.mem[9] = {6'b000100, 26'h2ab_cdef};   // learned b becomes plain
        flush_to(pc_of(0));
        wait_items(60);
        wait_bus_busy();
        flush_to(pc_of(0));
        wait_items(40);
        repeat (5) @(negedge clk);

        $display("errors: %0d checks, %0d assertions", errors, uut.u_chk.fail_count);
        if (errors == 0 && uut.u_chk.fail_count == 0 && !timed_out)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
source/fetch_pkg.sv
source/ras.sv
source/btb.sv
source/fetch1.sv
source/fetch2.sv
source/fetch_top.sv
testbench/imem_model.sv
testbench/fetch_chk.sv
testbench/tb_fetch.sv
